/* flist.f */
+incdir+hw
hw/wiscPkg.sv
hw/controlDecoder.sv
hw/immExtender.sv
hw/regFile.sv
hw/inFlightTracker.sv
hw/idStage.sv
hw/decodeTop.sv
tests/clockGen.sv
tests/decodeChecker.sv
tests/decodeTb.sv

/* tests/decodeTb.sv */
`timescale 1ns/1ps

module decodeTb import wiscPkg::*; ();

	localparam int PERIOD_NS = 40;
	localparam int DRIVE_DELAY_NS = 2;
	localparam int NUM_CYCLES = 600;
	localparam int TIMEOUT_NS = (NUM_CYCLES + 100) * PERIOD_NS;

	logic clk;
	logic rstN;
	word_t inst;
	word_t wbData;
	logic stall;
	logic haltN;
	ctrlBundle_t ctrl;
	word_t readData1;
	word_t readData2;
	word_t immExt;
	regSel_t destSel;
	int errCount;
	int checkCount;
	logic [31:0] lcgState;
	logic holdInst;

	// Every opcode of the decode table
	opcode_t knownOps [18] = '{
		5'b00000, 5'b00001, 5'b01000, 5'b01001, 5'b01010, 5'b01011,
		5'b10000, 5'b10001, 5'b11011, 5'b11000, 5'b10010, 5'b01100,
		5'b01101, 5'b01110, 5'b01111, 5'b00100, 5'b00110, 5'b00001
	};

	clockGen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3), .RELEASE_DELAY_NS(DRIVE_DELAY_NS)) clocks (
		.clk(clk),
		.rstN(rstN)
	);

	decodeTop uut (
		.clk(clk),
		.rstN(rstN),
		.inst(inst),
		.wbData(wbData),
		.stall(stall),
		.haltN(haltN),
		.ctrl(ctrl),
		.readData1(readData1),
		.readData2(readData2),
		.immExt(immExt),
		.destSel(destSel)
	);

	decodeChecker scoreboard (.*);

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Half table opcodes, half raw words
	function automatic word_t pickInst();
		logic [31:0] sel;
		logic [31:0] body;
		sel = nextRand();
		body = nextRand();
		if (sel[31])
			return {knownOps[sel[30:16] % 18], body[26:16]};
		return body[31:16];
	endfunction

	initial begin
		logic [31:0] r;
		lcgState = 32'h25af_ff56;
		inst = 16'h0800;
		wbData = '0;
		holdInst = 1'b0;
		@(posedge rstN);
		for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
			@(negedge clk);
			holdInst = stall;
			@(posedge clk);
			#DRIVE_DELAY_NS;
			if (!holdInst)
				inst = pickInst();
			r = nextRand();
			wbData = r[31:16];
		end
		repeat (2) @(negedge clk);
		$display("Run complete: %0d errors in %0d checks", errCount, checkCount);
		if (errCount == 0 && checkCount > 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#TIMEOUT_NS;
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Some tests failed");
		$finish;
	end

endmodule

/* tests/decodeChecker.sv */
`timescale 1ns/1ps
`include "wisc_params.svh"

module decodeChecker import wiscPkg::*; (
	input logic clk,
	input logic rstN,
	input word_t inst,
	input word_t wbData,
	input logic stall,
	input logic haltN,
	input ctrlBundle_t ctrl,
	input word_t readData1,
	input word_t readData2,
	input word_t immExt,
	input regSel_t destSel,
	output int errCount,
	output int checkCount
);

	word_t modelRegs [`WISC_NUM_REGS];
	inFlight_t modelSlots [`WISC_PIPE_SLOTS];
	ctrlBundle_t expCtrl;
	logic expHaltN;
	logic expStall;
	regSel_t expDest;
	word_t expImm;

	initial begin
		errCount = 0;
		checkCount = 0;
	end

	task automatic checkValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errCount++;
			$display("ERR %s expected %h actual %h at %0t ns", name, expected, actual, $time);
		end
	endtask

	task automatic decodeModel(input word_t instr);
		logic [4:0] op;
		op = instr[15:11];
		expCtrl = '0;
		expHaltN = 1'b1;
		expDest = instr[4:2];
		expImm = {11'b0, instr[4:0]};
		case (op)
			5'b00000: begin
				expHaltN = 1'b0;
				expCtrl.memDump = 1'b1;
			end
			5'b01000, 5'b01001, 5'b01010, 5'b01011: begin
				expCtrl.aluOp = {2'b01, op[1:0]};
				expCtrl.aluSrc2 = 1'b1;
				expCtrl.regWrite = 1'b1;
				expDest = instr[7:5];
				if (!op[1])
					expImm = {{11{instr[4]}}, instr[4:0]};
			end
			5'b10000, 5'b10001: begin
				expCtrl.aluSrc2 = 1'b1;
				expCtrl.memEn = 1'b1;
				expCtrl.memWrite = !op[0];
				expCtrl.memToReg = op[0];
				expCtrl.regWrite = op[0];
				// Only the load names rt as its destination
				if (op[0])
					expDest = instr[7:5];
				expImm = {{11{instr[4]}}, instr[4:0]};
			end
			5'b11011: begin
				expCtrl.aluOp = {2'b00, instr[1:0]};
				expCtrl.regWrite = 1'b1;
			end
			5'b11000, 5'b10010: begin
				expCtrl.regWrite = 1'b1;
				expDest = instr[10:8];
				expImm = op[4] && op[3] ? {{8{instr[7]}}, instr[7:0]} : {8'b0, instr[7:0]};
			end
			5'b01100, 5'b01101, 5'b01110, 5'b01111: begin
				expCtrl.pcSrc = 1'b1;
				expImm = {{8{instr[7]}}, instr[7:0]};
			end
			5'b00100, 5'b00110: begin
				expCtrl.jump = 1'b1;
				expCtrl.pcImm = 1'b1;
				expCtrl.regWrite = op[1];
				if (op[1])
					expDest = 3'd7;
				expImm = {{5{instr[10]}}, instr[10:0]};
			end
			default: ;
		endcase
	endtask

	function automatic logic hazard(input word_t instr);
		for (int i = 0; i < `WISC_PIPE_SLOTS; i++) begin
			if (modelSlots[i].regWrite &&
					(modelSlots[i].regSel == instr[10:8] || modelSlots[i].regSel == instr[7:5]))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// Inputs and outputs are settled mid-cycle
	always @(negedge clk) begin
		if (!rstN) begin
			foreach (modelRegs[i])
				modelRegs[i] = '0;
			foreach (modelSlots[i])
				modelSlots[i] = '0;
		end
		decodeModel(inst);
		expStall = hazard(inst);
		if (expStall) begin
			expCtrl.regWrite = 1'b0;
			expCtrl.memWrite = 1'b0;
			expCtrl.memEn = 1'b0;
			expCtrl.pcSrc = 1'b0;
			expCtrl.memDump = 1'b0;
			expCtrl.pcImm = 1'b0;
			expCtrl.jump = 1'b0;
		end
		checkValue("stall", expStall, stall);
		checkValue("haltN", expHaltN, haltN);
		checkValue("ctrl", expCtrl, ctrl);
		checkValue("destSel", expDest, destSel);
		checkValue("immExt", expImm, immExt);
		checkValue("readData1", modelRegs[inst[10:8]], readData1);
		checkValue("readData2", modelRegs[inst[7:5]], readData2);
		// State as it will be after the next rising edge
		if (rstN) begin
			if (modelSlots[`WISC_PIPE_SLOTS-1].regWrite)
				modelRegs[modelSlots[`WISC_PIPE_SLOTS-1].regSel] = wbData;
			for (int i = `WISC_PIPE_SLOTS - 1; i > 0; i--)
				modelSlots[i] = modelSlots[i-1];
			modelSlots[0] = '{regSel: expDest, regWrite: expCtrl.regWrite};
		end
	end

endmodule

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 3,
	parameter int RELEASE_DELAY_NS = 2
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Release just after a rising edge, like the other inputs
	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#RELEASE_DELAY_NS rstN = 1'b1;
	end

endmodule

/* hw/decodeTop.sv */
`timescale 1ns/1ps
`include "wisc_params.svh"

module decodeTop import wiscPkg::*; (
	input logic clk,
	input logic rstN,
	input word_t inst,
	input word_t wbData,
	output logic stall,
	output logic haltN,
	output ctrlBundle_t ctrl,
	output word_t readData1,
	output word_t readData2,
	output word_t immExt,
	output regSel_t destSel
);

	inFlight_t issue;
	inFlight_t wbCmd;
	inFlight_t slots [`WISC_PIPE_SLOTS];

	idStage decode (
		.clk(clk),
		.rstN(rstN),
		.inst(inst),
		.slots(slots),
		.wbCmd(wbCmd),
		.wbData(wbData),
		.ctrl(ctrl),
		.readData1(readData1),
		.readData2(readData2),
		.immExt(immExt),
		.destSel(destSel),
		.stall(stall),
		.haltN(haltN),
		.issue(issue)
	);

	inFlightTracker tracker (
		.clk(clk),
		.rstN(rstN),
		.issue(issue),
		.slots(slots),
		.wbCmd(wbCmd)
	);

endmodule

/* hw/idStage.sv */
`timescale 1ns/1ps
`include "wisc_params.svh"

module idStage import wiscPkg::*; (
	input logic clk,
	input logic rstN,
	input word_t inst,
	input inFlight_t slots [`WISC_PIPE_SLOTS],
	input inFlight_t wbCmd,
	input word_t wbData,
	output ctrlBundle_t ctrl,
	output word_t readData1,
	output word_t readData2,
	output word_t immExt,
	output regSel_t destSel,
	output logic stall,
	output logic haltN,
	output inFlight_t issue
);

	ctrlBundle_t ctrlRaw;
	extSel_t extSel;
	regDst_t regDst;
	regSel_t rsSel;
	regSel_t rtSel;

	assign rsSel = inst[10:8];
	assign rtSel = inst[7:5];

	controlDecoder decoder (
		.opcode(inst[15:11]),
		.funct(inst[1:0]),
		.ctrl(ctrlRaw),
		.extSel(extSel),
		.regDst(regDst),
		.haltN(haltN)
	);

	regFile regs (
		.clk(clk),
		.rstN(rstN),
		.readSel1(rsSel),
		.readSel2(rtSel),
		.writeSel(wbCmd.regSel),
		.writeEn(wbCmd.regWrite),
		.writeData(wbData),
		.readData1(readData1),
		.readData2(readData2)
	);

	immExtender extender (
		.field(inst[10:0]),
		.extSel(extSel),
		.immExt(immExt)
	);

	always_comb begin
		case (regDst)
			dstRd: destSel = inst[4:2];
			dstRt: destSel = rtSel;
			dstRs: destSel = rsSel;
			default: destSel = 3'd7;
		endcase
	end

	// Both fields are compared whatever the opcode
	always_comb begin
		stall = 1'b0;
		for (int i = 0; i < `WISC_PIPE_SLOTS; i++) begin
			if (slots[i].regWrite && (slots[i].regSel == rsSel || slots[i].regSel == rtSel))
				stall = 1'b1;
		end
	end

	always_comb begin
		ctrl = ctrlRaw;
		if (stall) begin
			ctrl.regWrite = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.memEn = 1'b0;
			ctrl.pcSrc = 1'b0;
			ctrl.memDump = 1'b0;
			ctrl.pcImm = 1'b0;
			ctrl.jump = 1'b0;
		end
	end

	// Bubble goes downstream while stalled
	assign issue = '{regSel: destSel, regWrite: ctrl.regWrite};

	// A stalled instruction must not write memory, redirect the PC or claim a slot
	assert property (@(posedge clk) disable iff (!rstN)
		stall |-> !(ctrl.memWrite || ctrl.jump || ctrl.pcSrc || issue.regWrite));

endmodule

/* hw/inFlightTracker.sv */
`timescale 1ns/1ps
`include "wisc_params.svh"

module inFlightTracker import wiscPkg::*; (
	input logic clk,
	input logic rstN,
	input inFlight_t issue,
	output inFlight_t slots [`WISC_PIPE_SLOTS],
	output inFlight_t wbCmd
);

	// Slot 0 is execute, the last slot is writeback
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `WISC_PIPE_SLOTS; i++)
				slots[i] <= '0;
		end else begin
			slots[0] <= issue;
			for (int i = 1; i < `WISC_PIPE_SLOTS; i++)
				slots[i] <= slots[i-1];
		end
	end

	assign wbCmd = slots[`WISC_PIPE_SLOTS-1];

	// Every register write traces back to an entry issued by decode
	assert property (@(posedge clk) disable iff (!rstN)
		wbCmd.regWrite |-> wbCmd == $past(issue, `WISC_PIPE_SLOTS));

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps
`include "wisc_params.svh"

module regFile import wiscPkg::*; (
	input logic clk,
	input logic rstN,
	input regSel_t readSel1,
	input regSel_t readSel2,
	input regSel_t writeSel,
	input logic writeEn,
	input word_t writeData,
	output word_t readData1,
	output word_t readData2
);

	word_t regs [`WISC_NUM_REGS];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `WISC_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (writeEn) begin
			regs[writeSel] <= writeData;
		end
	end

	// No write-through, the hazard stall covers RAW
	assign readData1 = regs[readSel1];
	assign readData2 = regs[readSel2];

endmodule

/* hw/immExtender.sv */
`timescale 1ns/1ps

module immExtender import wiscPkg::*; (
	input logic [10:0] field,
	input extSel_t extSel,
	output word_t immExt
);

	word_t zeroExt5;
	word_t zeroExt8;
	word_t signExt5;
	word_t signExt8;
	word_t signExt11;

	assign zeroExt5 = {11'b0, field[4:0]};
	assign zeroExt8 = {8'b0, field[7:0]};
	assign signExt5 = {{11{field[4]}}, field[4:0]};
	assign signExt8 = {{8{field[7]}}, field[7:0]};
	assign signExt11 = {{5{field[10]}}, field};

	always_comb begin
		case (extSel)
			zero5: immExt = zeroExt5;
			zero8: immExt = zeroExt8;
			sign5: immExt = signExt5;
			sign8: immExt = signExt8;
			sign11: immExt = signExt11;
			default: immExt = '0;
		endcase
	end

endmodule

/* hw/controlDecoder.sv */
`timescale 1ns/1ps

module controlDecoder import wiscPkg::*; (
	input opcode_t opcode,
	input logic [1:0] funct,
	output ctrlBundle_t ctrl,
	output extSel_t extSel,
	output regDst_t regDst,
	output logic haltN
);

	always_comb begin
		ctrl = '0;
		extSel = zero5;
		regDst = dstRd;
		haltN = 1'b1;
		case (opcode)
			5'b00000: begin
				// Halt also dumps data memory
				haltN = 1'b0;
				ctrl.memDump = 1'b1;
			end
			5'b01000, 5'b01001, 5'b01010, 5'b01011: begin
				// ADDI and SUBI sign extend, XORI and ANDNI zero extend
				ctrl.aluOp = {2'b01, opcode[1:0]};
				ctrl.aluSrc2 = 1'b1;
				ctrl.regWrite = 1'b1;
				regDst = dstRt;
				extSel = opcode[1] ? zero5 : sign5;
			end
			5'b10000: begin
				ctrl.aluSrc2 = 1'b1;
				ctrl.memEn = 1'b1;
				ctrl.memWrite = 1'b1;
				extSel = sign5;
			end
			5'b10001: begin
				ctrl.aluSrc2 = 1'b1;
				ctrl.memEn = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
				regDst = dstRt;
				extSel = sign5;
			end
			5'b11011: begin
				ctrl.aluOp = {2'b00, funct};
				ctrl.regWrite = 1'b1;
				regDst = dstRd;
			end
			5'b11000: begin
				ctrl.regWrite = 1'b1;
				regDst = dstRs;
				extSel = sign8;
			end
			5'b10010: begin
				ctrl.regWrite = 1'b1;
				regDst = dstRs;
				extSel = zero8;
			end
			5'b01100, 5'b01101, 5'b01110, 5'b01111: begin
				ctrl.pcSrc = 1'b1;
				extSel = sign8;
			end
			5'b00100: begin
				ctrl.jump = 1'b1;
				ctrl.pcImm = 1'b1;
				extSel = sign11;
			end
			5'b00110: begin
				// JAL links into r7
				ctrl.jump = 1'b1;
				ctrl.pcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				regDst = dstLink;
				extSel = sign11;
			end
			default: begin
				// NOP and every unused opcode keep the defaults
				ctrl = '0;
			end
		endcase
	end

	// A clean opcode must always pick a defined extension
	always_comb begin
		if (!$isunknown(opcode)) begin
			assert final (!$isunknown(extSel))
			else $error("extSel unknown for opcode %h", opcode);
		end
	end

endmodule

/* hw/wiscPkg.sv */
package wiscPkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] regSel_t;

	// Inst[15:11]
	typedef logic [4:0] opcode_t;

	typedef logic [3:0] aluOp_t;

	// Immediate kinds, widths 5, 8 and 11
	typedef enum logic [2:0] {
		zero5,
		zero8,
		sign5,
		sign8,
		sign11
	} extSel_t;

	// Where the written register number comes from
	typedef enum logic [1:0] {
		dstRd,
		dstRt,
		dstRs,
		dstLink
	} regDst_t;

	typedef struct packed {
		aluOp_t aluOp;
		logic aluSrc2;
		logic memEn;
		logic memWrite;
		logic memToReg;
		logic memDump;
		logic pcSrc;
		logic pcImm;
		logic jump;
		logic regWrite;
	} ctrlBundle_t;

	typedef struct packed {
		regSel_t regSel;
		logic regWrite;
	} inFlight_t;

endpackage

/* hw/wisc_params.svh */
`ifndef WISC_PARAMS_SVH
`define WISC_PARAMS_SVH

// General purpose registers r0 to r7
`define WISC_NUM_REGS 8

// Slots after decode that can still hold a pending write
// Order is execute, memory, writeback
`define WISC_PIPE_SLOTS 3

`endif
